/* hw/dcache_pkg.sv */
package dcache_pkg;

    // Cache geometry
    localparam int ADDR_BITS     = 32;
    localparam int DATA_WIDTH    = 32;
    localparam int BLOCK_WIDTH   = 256;
    localparam int ASSOCIATIVITY = 4;
    localparam int ENTRIES       = 16;
    localparam int BUFFER_DEPTH  = 4;
    localparam int R_WIDTH       = 6;
    localparam int ROB_TICKET    = 3;

    // Address fields, byte offset within a line at the bottom
    localparam int OFFSET_BITS     = $clog2(BLOCK_WIDTH / 8);
    localparam int INDEX_BITS      = $clog2(ENTRIES);
    localparam int TAG_BITS        = ADDR_BITS - INDEX_BITS - OFFSET_BITS;
    localparam int WAY_BITS        = $clog2(ASSOCIATIVITY);
    localparam int WORD_BITS       = $clog2(BLOCK_WIDTH / DATA_WIDTH);
    localparam int BUFFER_PTR_BITS = $clog2(BUFFER_DEPTH);

    typedef logic [TAG_BITS-1:0]    tag_t;
    typedef logic [BLOCK_WIDTH-1:0] block_t;
    typedef logic [WAY_BITS-1:0]    way_t;
    typedef logic [INDEX_BITS-1:0]  index_t;

    // Word of a line addressed by the word bits of addr
    function automatic logic [DATA_WIDTH-1:0] select_word(block_t blk,
                                                          logic [ADDR_BITS-1:0] addr);
        logic [WORD_BITS-1:0] sel;
        sel = addr[OFFSET_BITS-1 -: WORD_BITS];
        return blk[sel*DATA_WIDTH +: DATA_WIDTH];
    endfunction

    // True when both addresses fall in one line
    function automatic logic same_block(logic [ADDR_BITS-1:0] a, logic [ADDR_BITS-1:0] b);
        return a[ADDR_BITS-1:OFFSET_BITS] == b[ADDR_BITS-1:OFFSET_BITS];
    endfunction

endpackage

/* hw/line_ram.sv */
`timescale 1ns/10ps

module line_ram #(
    parameter type entry_t = logic
) (
    input  logic                clk,
    input  dcache_pkg::index_t  rd_index,
    output entry_t              rd_entry,
    input  logic                wr_en,
    input  dcache_pkg::index_t  wr_index,
    input  entry_t              wr_entry
);

    entry_t mem [dcache_pkg::ENTRIES];

    // Read sees the old line until the write edge
    assign rd_entry = mem[rd_index];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_index] <= wr_entry;
        end
    end

endmodule

/* hw/lru_policy.sv */
`timescale 1ns/10ps

module lru_policy (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                touch,
    input  dcache_pkg::index_t  touch_index,
    input  dcache_pkg::way_t    touch_way,
    input  dcache_pkg::index_t  victim_index,
    output dcache_pkg::way_t    victim_way
);

    // Age 0 is the newest, ASSOCIATIVITY-1 the oldest
    dcache_pkg::way_t age [dcache_pkg::ENTRIES][dcache_pkg::ASSOCIATIVITY];

    always_comb begin
        victim_way = '0;
        for (int w = 0; w < dcache_pkg::ASSOCIATIVITY; w++) begin
            if (age[victim_index][w] == dcache_pkg::way_t'(dcache_pkg::ASSOCIATIVITY - 1)) begin
                victim_way = dcache_pkg::way_t'(w);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < dcache_pkg::ENTRIES; s++) begin
                for (int w = 0; w < dcache_pkg::ASSOCIATIVITY; w++) begin
                    age[s][w] <= dcache_pkg::way_t'(dcache_pkg::ASSOCIATIVITY - 1 - w);
                end
            end
        end else if (touch) begin
            for (int w = 0; w < dcache_pkg::ASSOCIATIVITY; w++) begin
                if (dcache_pkg::way_t'(w) == touch_way) begin
                    age[touch_index][w] <= '0;
                end else if (age[touch_index][w] < age[touch_index][touch_way]) begin
                    // Younger than the touched way, so one step older now
                    age[touch_index][w] <= age[touch_index][w] + 1'b1;
                end
            end
        end
    end

endmodule

/* hw/cache_ways.sv */
`timescale 1ns/10ps

module cache_ways (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [dcache_pkg::ADDR_BITS-1:0]  lookup_address,
    input  logic                              lookup_en,
    output logic                              hit,
    output logic [dcache_pkg::DATA_WIDTH-1:0] hit_word,
    input  logic                              update_l2_valid,
    input  logic [dcache_pkg::ADDR_BITS-1:0]  update_l2_addr,
    input  dcache_pkg::block_t                update_l2_data
);

    dcache_pkg::index_t lookup_index;
    dcache_pkg::index_t update_index;
    dcache_pkg::tag_t   lookup_tag;
    dcache_pkg::tag_t   update_tag;
    dcache_pkg::tag_t   tag_rd   [dcache_pkg::ASSOCIATIVITY];
    dcache_pkg::block_t block_rd [dcache_pkg::ASSOCIATIVITY];
    dcache_pkg::block_t hit_block;
    dcache_pkg::way_t   hit_way;
    dcache_pkg::way_t   fill_way;
    dcache_pkg::way_t   victim_way;
    logic [dcache_pkg::ASSOCIATIVITY-1:0] valid [dcache_pkg::ENTRIES];

    assign lookup_index = lookup_address[dcache_pkg::OFFSET_BITS +: dcache_pkg::INDEX_BITS];
    assign update_index = update_l2_addr[dcache_pkg::OFFSET_BITS +: dcache_pkg::INDEX_BITS];
    assign lookup_tag   = lookup_address[dcache_pkg::ADDR_BITS-1 -: dcache_pkg::TAG_BITS];
    assign update_tag   = update_l2_addr[dcache_pkg::ADDR_BITS-1 -: dcache_pkg::TAG_BITS];

    for (genvar w = 0; w < dcache_pkg::ASSOCIATIVITY; w++) begin : gen_way
        logic wr_en;
        assign wr_en = update_l2_valid && (fill_way == dcache_pkg::way_t'(w));

        line_ram #(.entry_t(dcache_pkg::tag_t)) u_tag_ram (
            .clk      (clk),
            .rd_index (lookup_index),
            .rd_entry (tag_rd[w]),
            .wr_en    (wr_en),
            .wr_index (update_index),
            .wr_entry (update_tag)
        );

        line_ram #(.entry_t(dcache_pkg::block_t)) u_data_ram (
            .clk      (clk),
            .rd_index (lookup_index),
            .rd_entry (block_rd[w]),
            .wr_en    (wr_en),
            .wr_index (update_index),
            .wr_entry (update_l2_data)
        );
    end

    // Tag compare across all ways of the set
    always_comb begin
        hit       = 1'b0;
        hit_way   = '0;
        hit_block = block_rd[0];
        for (int w = 0; w < dcache_pkg::ASSOCIATIVITY; w++) begin
            if (valid[lookup_index][w] && tag_rd[w] == lookup_tag) begin
                hit       = 1'b1;
                hit_way   = dcache_pkg::way_t'(w);
                hit_block = block_rd[w];
            end
        end
    end

    assign hit_word = dcache_pkg::select_word(hit_block, lookup_address);

    // Lowest invalid way, else the LRU victim
    always_comb begin
        fill_way = victim_way;
        for (int w = dcache_pkg::ASSOCIATIVITY - 1; w >= 0; w--) begin
            if (!valid[update_index][w]) begin
                fill_way = dcache_pkg::way_t'(w);
            end
        end
    end

    lru_policy u_lru (
        .clk          (clk),
        .rst_n        (rst_n),
        .touch        (update_l2_valid || (lookup_en && hit)),
        .touch_index  (update_l2_valid ? update_index : lookup_index),
        .touch_way    (update_l2_valid ? fill_way : hit_way),
        .victim_index (update_index),
        .victim_way   (victim_way)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < dcache_pkg::ENTRIES; s++) begin
                valid[s] <= '0;
            end
        end else if (update_l2_valid) begin
            valid[update_index][fill_way] <= 1'b1;
        end
    end

endmodule

/* hw/load_miss_buffer.sv */
`timescale 1ns/10ps

module load_miss_buffer (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              push,
    input  logic [dcache_pkg::ADDR_BITS-1:0]  push_address,
    input  logic [dcache_pkg::R_WIDTH-1:0]    push_dest,
    input  logic [dcache_pkg::ROB_TICKET-1:0] push_ticket,
    input  logic                              pop,
    input  logic                              update_l2_valid,
    input  logic [dcache_pkg::ADDR_BITS-1:0]  update_l2_addr,
    input  dcache_pkg::block_t                update_l2_data,
    output logic                              pending_match,
    output logic                              full,
    output logic                              head_fetched,
    output logic [dcache_pkg::R_WIDTH-1:0]    head_dest,
    output logic [dcache_pkg::ROB_TICKET-1:0] head_ticket,
    output logic [dcache_pkg::DATA_WIDTH-1:0] head_word
);

    logic [dcache_pkg::BUFFER_PTR_BITS-1:0] head;
    logic [dcache_pkg::BUFFER_PTR_BITS-1:0] tail;
    logic [dcache_pkg::BUFFER_DEPTH-1:0]    ent_valid;
    logic [dcache_pkg::BUFFER_DEPTH-1:0]    ent_fetched;
    logic [dcache_pkg::BUFFER_DEPTH-1:0]    fill;
    logic [dcache_pkg::ADDR_BITS-1:0]       ent_addr   [dcache_pkg::BUFFER_DEPTH];
    logic [dcache_pkg::R_WIDTH-1:0]         ent_dest   [dcache_pkg::BUFFER_DEPTH];
    logic [dcache_pkg::ROB_TICKET-1:0]      ent_ticket [dcache_pkg::BUFFER_DEPTH];
    logic [dcache_pkg::DATA_WIDTH-1:0]      ent_word   [dcache_pkg::BUFFER_DEPTH];
    logic [dcache_pkg::DATA_WIDTH-1:0]      fill_word  [dcache_pkg::BUFFER_DEPTH];

    // Refill match per entry, the slot being pushed included
    always_comb begin
        logic                             is_push_slot;
        logic [dcache_pkg::ADDR_BITS-1:0] cur_addr;
        for (int i = 0; i < dcache_pkg::BUFFER_DEPTH; i++) begin
            is_push_slot = push && (int'(tail) == i);
            cur_addr     = is_push_slot ? push_address : ent_addr[i];
            fill[i]      = update_l2_valid
                           && (is_push_slot || (ent_valid[i] && !ent_fetched[i]))
                           && dcache_pkg::same_block(cur_addr, update_l2_addr);
            fill_word[i] = dcache_pkg::select_word(update_l2_data, cur_addr);
        end
    end

    // Block still on its way from L2
    always_comb begin
        pending_match = 1'b0;
        for (int i = 0; i < dcache_pkg::BUFFER_DEPTH; i++) begin
            if (ent_valid[i] && !ent_fetched[i]
                && dcache_pkg::same_block(ent_addr[i], push_address)) begin
                pending_match = 1'b1;
            end
        end
    end

    assign full         = &ent_valid;
    assign head_fetched = ent_valid[head] && ent_fetched[head];
    assign head_dest    = ent_dest[head];
    assign head_ticket  = ent_ticket[head];
    assign head_word    = ent_word[head];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head        <= '0;
            tail        <= '0;
            ent_valid   <= '0;
            ent_fetched <= '0;
        end else begin
            if (push) begin
                ent_valid[tail]   <= 1'b1;
                ent_fetched[tail] <= 1'b0;
                tail              <= tail + 1'b1;
            end
            if (pop) begin
                ent_valid[head] <= 1'b0;
                head            <= head + 1'b1;
            end
            // Refill overrides the cleared flag of a fresh push
            for (int i = 0; i < dcache_pkg::BUFFER_DEPTH; i++) begin
                if (fill[i]) begin
                    ent_fetched[i] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            ent_addr[tail]   <= push_address;
            ent_dest[tail]   <= push_dest;
            ent_ticket[tail] <= push_ticket;
        end
        for (int i = 0; i < dcache_pkg::BUFFER_DEPTH; i++) begin
            if (fill[i]) begin
                ent_word[i] <= fill_word[i];
            end
        end
    end

endmodule

/* hw/load_serve_ctrl.sv */
`timescale 1ns/10ps

module load_serve_ctrl (
    input  logic                              load_valid,
    input  logic [dcache_pkg::ADDR_BITS-1:0]  load_address,
    input  logic [dcache_pkg::R_WIDTH-1:0]    load_dest,
    input  logic [dcache_pkg::ROB_TICKET-1:0] load_ticket,
    input  logic                              output_used,
    input  logic                              hit,
    input  logic [dcache_pkg::DATA_WIDTH-1:0] hit_word,
    input  logic                              pending_match,
    input  logic                              full,
    input  logic                              head_fetched,
    input  logic [dcache_pkg::R_WIDTH-1:0]    head_dest,
    input  logic [dcache_pkg::ROB_TICKET-1:0] head_ticket,
    input  logic [dcache_pkg::DATA_WIDTH-1:0] head_word,
    input  logic                              update_l2_valid,
    input  logic [dcache_pkg::ADDR_BITS-1:0]  update_l2_addr,
    output logic                              load_blocked,
    output logic                              lookup_en,
    output logic                              push,
    output logic                              pop,
    output logic                              request_l2_valid,
    output logic [dcache_pkg::ADDR_BITS-1:0]  request_l2_addr,
    output logic                              served_valid,
    output logic [dcache_pkg::R_WIDTH-1:0]    served_dest,
    output logic [dcache_pkg::ROB_TICKET-1:0] served_ticket,
    output logic [dcache_pkg::DATA_WIDTH-1:0] served_data
);

    logic accept;
    logic arriving;

    assign load_blocked = output_used || full;
    assign accept       = load_valid && !load_blocked;
    assign lookup_en    = accept;

    // Miss goes to the buffer; L2 is asked only once per block
    assign arriving         = update_l2_valid && dcache_pkg::same_block(update_l2_addr, load_address);
    assign push             = accept && !hit;
    assign request_l2_valid = push && !pending_match && !arriving;
    assign request_l2_addr  = load_address;

    // Buffer head only gets the port when no new load takes it
    assign pop          = !accept && head_fetched && !output_used;
    assign served_valid = (accept && hit) || pop;

    assign served_dest   = accept ? load_dest   : head_dest;
    assign served_ticket = accept ? load_ticket : head_ticket;
    assign served_data   = accept ? hit_word    : head_word;

endmodule

/* hw/data_cache.sv */
`timescale 1ns/10ps

module data_cache (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              load_valid,
    input  logic [dcache_pkg::ADDR_BITS-1:0]  load_address,
    input  logic [dcache_pkg::R_WIDTH-1:0]    load_dest,
    input  logic [dcache_pkg::ROB_TICKET-1:0] load_ticket,
    input  logic                              output_used,
    input  logic                              update_l2_valid,
    input  logic [dcache_pkg::ADDR_BITS-1:0]  update_l2_addr,
    input  dcache_pkg::block_t                update_l2_data,
    output logic                              load_blocked,
    output logic                              served_valid,
    output logic [dcache_pkg::R_WIDTH-1:0]    served_dest,
    output logic [dcache_pkg::ROB_TICKET-1:0] served_ticket,
    output logic [dcache_pkg::DATA_WIDTH-1:0] served_data,
    output logic                              request_l2_valid,
    output logic [dcache_pkg::ADDR_BITS-1:0]  request_l2_addr
);

    logic                              lookup_en;
    logic                              hit;
    logic [dcache_pkg::DATA_WIDTH-1:0] hit_word;
    logic                              push;
    logic                              pop;
    logic                              pending_match;
    logic                              full;
    logic                              head_fetched;
    logic [dcache_pkg::R_WIDTH-1:0]    head_dest;
    logic [dcache_pkg::ROB_TICKET-1:0] head_ticket;
    logic [dcache_pkg::DATA_WIDTH-1:0] head_word;

    // Only a new load is ever looked up
    cache_ways u_ways (
        .clk             (clk),
        .rst_n           (rst_n),
        .lookup_address  (load_address),
        .lookup_en       (lookup_en),
        .hit             (hit),
        .hit_word        (hit_word),
        .update_l2_valid (update_l2_valid),
        .update_l2_addr  (update_l2_addr),
        .update_l2_data  (update_l2_data)
    );

    load_miss_buffer u_miss_buffer (
        .clk             (clk),
        .rst_n           (rst_n),
        .push            (push),
        .push_address    (load_address),
        .push_dest       (load_dest),
        .push_ticket     (load_ticket),
        .pop             (pop),
        .update_l2_valid (update_l2_valid),
        .update_l2_addr  (update_l2_addr),
        .update_l2_data  (update_l2_data),
        .pending_match   (pending_match),
        .full            (full),
        .head_fetched    (head_fetched),
        .head_dest       (head_dest),
        .head_ticket     (head_ticket),
        .head_word       (head_word)
    );

    load_serve_ctrl u_serve_ctrl (
        .load_valid       (load_valid),
        .load_address     (load_address),
        .load_dest        (load_dest),
        .load_ticket      (load_ticket),
        .output_used      (output_used),
        .hit              (hit),
        .hit_word         (hit_word),
        .pending_match    (pending_match),
        .full             (full),
        .head_fetched     (head_fetched),
        .head_dest        (head_dest),
        .head_ticket      (head_ticket),
        .head_word        (head_word),
        .update_l2_valid  (update_l2_valid),
        .update_l2_addr   (update_l2_addr),
        .load_blocked     (load_blocked),
        .lookup_en        (lookup_en),
        .push             (push),
        .pop              (pop),
        .request_l2_valid (request_l2_valid),
        .request_l2_addr  (request_l2_addr),
        .served_valid     (served_valid),
        .served_dest      (served_dest),
        .served_ticket    (served_ticket),
        .served_data      (served_data)
    );

endmodule

/* verification/data_cache_tb.sv */
`timescale 1ns/10ps

module data_cache_tb;

    typedef enum {EXPECT_ANY, EXPECT_HIT, EXPECT_MISS, EXPECT_NOREQ} expect_e;

    logic                              clk;
    logic                              rst_n;
    logic                              load_valid;
    logic [dcache_pkg::ADDR_BITS-1:0]  load_address;
    logic [dcache_pkg::R_WIDTH-1:0]    load_dest;
    logic [dcache_pkg::ROB_TICKET-1:0] load_ticket;
    logic                              output_used;
    logic                              update_l2_valid;
    logic [dcache_pkg::ADDR_BITS-1:0]  update_l2_addr;
    dcache_pkg::block_t                update_l2_data;
    logic                              load_blocked;
    logic                              served_valid;
    logic [dcache_pkg::R_WIDTH-1:0]    served_dest;
    logic [dcache_pkg::ROB_TICKET-1:0] served_ticket;
    logic [dcache_pkg::DATA_WIDTH-1:0] served_data;
    logic                              request_l2_valid;
    logic [dcache_pkg::ADDR_BITS-1:0]  request_l2_addr;

    // Scoreboard of sent loads, oldest first
    logic [dcache_pkg::ADDR_BITS-1:0]  sb_addr [$];
    logic [dcache_pkg::R_WIDTH-1:0]    sb_dest [$];
    logic [dcache_pkg::ROB_TICKET-1:0] sb_ticket [$];
    // L2 model queue with the cycle each answer is due
    logic [dcache_pkg::ADDR_BITS-1:0]  l2_addr_q [$];
    int                                l2_due_q [$];
    logic                              l2_hold;
    int                                cycle_count;
    int                                load_id;
    int                                directed_loads = 15;
    int                                random_loads = 24;
    logic [31:0]                       stim_rng;
    logic [dcache_pkg::ADDR_BITS-1:0]  rand_addr;

    data_cache u_dut (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // Memory word is its word address mixed with a constant
    function automatic logic [dcache_pkg::DATA_WIDTH-1:0] ref_word(
            input logic [dcache_pkg::ADDR_BITS-1:0] addr);
        return (addr >> 2) ^ 32'h9E37_79B9;
    endfunction

    function automatic dcache_pkg::block_t build_line(input logic [dcache_pkg::ADDR_BITS-1:0] addr);
        dcache_pkg::block_t               blk;
        logic [dcache_pkg::ADDR_BITS-1:0] base;
        base = (addr >> dcache_pkg::OFFSET_BITS) << dcache_pkg::OFFSET_BITS;
        for (int w = 0; w < dcache_pkg::BLOCK_WIDTH / dcache_pkg::DATA_WIDTH; w++) begin
            blk[w*dcache_pkg::DATA_WIDTH +: dcache_pkg::DATA_WIDTH] =
                ref_word(base + w * (dcache_pkg::DATA_WIDTH / 8));
        end
        return blk;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error: %s is 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    // A hit serves the load accepted now and the buffer serves the oldest load
    task automatic match_served(input logic accepted);
        int idx;
        if (sb_addr.size() == 0) begin
            abort_run("A load was served that was never sent");
        end else begin
            idx = accepted ? sb_addr.size() - 1 : 0;
            check_value("served_dest", 64'(served_dest), 64'(sb_dest[idx]));
            check_value("served_ticket", 64'(served_ticket), 64'(sb_ticket[idx]));
            check_value("served_data", 64'(served_data), 64'(ref_word(sb_addr[idx])));
            sb_addr.delete(idx);
            sb_dest.delete(idx);
            sb_ticket.delete(idx);
        end
    endtask

    task automatic post_load(input logic [dcache_pkg::ADDR_BITS-1:0] addr);
        load_valid   = 1'b1;
        load_address = addr;
        load_dest    = load_id[dcache_pkg::R_WIDTH-1:0];
        load_ticket  = load_id[dcache_pkg::ROB_TICKET-1:0];
        sb_addr.push_back(addr);
        sb_dest.push_back(load_dest);
        sb_ticket.push_back(load_ticket);
        load_id++;
    endtask

    // Holds the load until accepted, then checks the acceptance cycle
    task automatic wait_accept(input expect_e kind);
        @(posedge clk);
        while (load_blocked) begin
            @(posedge clk);
        end
        case (kind)
            EXPECT_HIT: begin
                check_value("served_valid", 64'(served_valid), 64'd1);
                check_value("request_l2_valid", 64'(request_l2_valid), 64'd0);
            end
            EXPECT_MISS: begin
                check_value("served_valid", 64'(served_valid), 64'd0);
                check_value("request_l2_valid", 64'(request_l2_valid), 64'd1);
                check_value("request_l2_addr", 64'(request_l2_addr), 64'(load_address));
            end
            EXPECT_NOREQ: check_value("request_l2_valid", 64'(request_l2_valid), 64'd0);
            default: ;
        endcase
        @(negedge clk);
        load_valid = 1'b0;
    endtask

    task automatic send_load(input logic [dcache_pkg::ADDR_BITS-1:0] addr, input expect_e kind);
        post_load(addr);
        wait_accept(kind);
    endtask

    task automatic drain();
        while (sb_addr.size() != 0) begin
            @(negedge clk);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // L2 model answering one request per cycle in request order
    initial begin
        logic [31:0] l2_rng;
        l2_rng          = 32'd99662;
        update_l2_valid = 1'b0;
        update_l2_addr  = '0;
        update_l2_data  = '0;
        cycle_count     = 0;
        forever begin
            @(posedge clk);
            cycle_count++;
            if (request_l2_valid) begin
                l2_rng = xorshift(l2_rng);
                l2_addr_q.push_back(request_l2_addr);
                l2_due_q.push_back(cycle_count + int'(l2_rng % 6));
            end
            @(negedge clk);
            update_l2_valid = 1'b0;
            if (!l2_hold && l2_addr_q.size() != 0 && l2_due_q[0] <= cycle_count) begin
                update_l2_valid = 1'b1;
                update_l2_addr  = l2_addr_q.pop_front();
                update_l2_data  = build_line(update_l2_addr);
                void'(l2_due_q.pop_front());
            end
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            if (rst_n && served_valid) begin
                match_served(load_valid && !load_blocked);
            end
        end
    end

    initial begin
        int budget;
        // Reset plus a worst case miss latency for every load
        budget = 16 + (directed_loads + random_loads) * 40;
        repeat (budget) @(posedge clk);
        abort_run("Timeout: loads were still outstanding when the cycle budget ran out");
    end

    initial begin
        rst_n        = 1'b0;
        load_valid   = 1'b0;
        load_address = '0;
        load_dest    = '0;
        load_ticket  = '0;
        output_used  = 1'b0;
        l2_hold      = 1'b0;
        load_id      = 0;
        stim_rng     = 32'd99662;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(posedge clk);
        check_value("served_valid", 64'(served_valid), 64'd0);
        check_value("request_l2_valid", 64'(request_l2_valid), 64'd0);
        check_value("load_blocked", 64'(load_blocked), 64'd0);
        @(negedge clk);

        send_load(32'h0000_1004, EXPECT_MISS);
        drain();
        send_load(32'h0000_1010, EXPECT_HIT);
        drain();
        // Second load merges into the pending block
        send_load(32'h0000_2024, EXPECT_MISS);
        send_load(32'h0000_2038, EXPECT_NOREQ);
        drain();

        // Fill the miss buffer while L2 is held back
        @(posedge clk);
        l2_hold = 1'b1;
        @(negedge clk);
        for (int k = 0; k < dcache_pkg::BUFFER_DEPTH; k++) begin
            send_load(32'h0000_3060 + k * 32, EXPECT_MISS);
        end
        @(posedge clk);
        check_value("load_blocked", 64'(load_blocked), 64'd1);
        l2_hold = 1'b0;
        @(posedge clk);
        while (!served_valid) begin
            @(posedge clk);
        end
        @(posedge clk);
        check_value("load_blocked", 64'(load_blocked), 64'd0);

        // output_used stalls both the new load and the buffer head
        @(negedge clk);
        output_used = 1'b1;
        post_load(32'h0000_4100);
        repeat (8) begin
            @(posedge clk);
            check_value("load_blocked", 64'(load_blocked), 64'd1);
            check_value("served_valid", 64'(served_valid), 64'd0);
        end
        @(negedge clk);
        output_used = 1'b0;
        wait_accept(EXPECT_MISS);
        drain();

        // Five blocks into set 2 make the first refill the LRU victim
        for (int k = 0; k < 5; k++) begin
            send_load(32'h0001_0040 + k * 32'h200, EXPECT_MISS);
            drain();
        end
        send_load(32'h0001_0040, EXPECT_MISS);
        drain();

        // Random loads over eight tags in sets 10 and 11
        for (int n = 0; n < random_loads; n++) begin
            stim_rng        = xorshift(stim_rng);
            rand_addr       = 32'h0002_0140;
            rand_addr[11:9] = stim_rng[2:0];
            rand_addr[5]    = stim_rng[3];
            rand_addr[4:2]  = stim_rng[6:4];
            send_load(rand_addr, EXPECT_ANY);
            if (stim_rng[7]) begin
                @(negedge clk);
            end
        end
        drain();

        repeat (4) @(negedge clk);
        $display("All tests passed");
        $finish;
    end

endmodule

/* build.f */
hw/dcache_pkg.sv
hw/line_ram.sv
hw/lru_policy.sv
hw/cache_ways.sv
hw/load_miss_buffer.sv
hw/load_serve_ctrl.sv
hw/data_cache.sv
verification/data_cache_tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing
TOP      = data_cache_tb
FILELIST = build.f

.PHONY: simulate clean

simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir
